// ==== logic/npu_pkg.sv ====
// ================================================
// Shared widths, vector types, register map and FSM
// encodings for the NPU slice. Every RTL file and the
// testbench refer to these by scoped name.
// ================================================
`default_nettype none

package npu_pkg;

    // Datapath shape, tied to the 32-bit bus word
    localparam int LANES  = 4;
    localparam int LANE_W = 8;

    typedef logic        [31:0]       word_t;
    typedef logic signed [LANE_W-1:0] lane_t;
    typedef logic signed [31:0]       acc_t;
    typedef logic        [11:0]       reg_addr_t;

    localparam word_t NPU_VERSION = 32'h0001_0000;

    // ================================================
    // Register map (byte offsets)
    // ================================================
    localparam reg_addr_t REG_CTRL       = 12'h000;
    localparam reg_addr_t REG_STATUS     = 12'h004;
    localparam reg_addr_t REG_IRQ_EN     = 12'h008;
    localparam reg_addr_t REG_IRQ_STATUS = 12'h00C;
    localparam reg_addr_t REG_VERSION    = 12'h010;
    localparam reg_addr_t REG_CONFIG     = 12'h014;
    localparam reg_addr_t REG_LEN        = 12'h018;
    localparam reg_addr_t REG_RESULT     = 12'h01C;

    // Buffer windows, 256 bytes each
    localparam reg_addr_t WGT_BASE = 12'h100;
    localparam reg_addr_t ACT_BASE = 12'h200;

    // Code 3 is treated as no activation
    typedef enum logic [1:0] {
        ACT_NONE      = 2'd0,
        ACT_RELU      = 2'd1,
        ACT_RELU_CLIP = 2'd2
    } act_type_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STREAM,
        ST_DRAIN,
        ST_FINISH
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== logic/npu_buffer.sv ====
// ================================================
// Single-clock word buffer, one write port and one
// registered read port. Used for weights and inputs.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module npu_buffer #(
    parameter int BUF_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  logic [$clog2(BUF_DEPTH)-1:0]   wr_addr,
    input  npu_pkg::word_t                 wr_data,
    input  logic                           rd_en,
    input  logic [$clog2(BUF_DEPTH)-1:0]   rd_addr,
    output npu_pkg::word_t                 rd_data,
    output logic                           rd_valid
);

    npu_pkg::word_t mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // Writes are blocked while busy, so no read/write collision
    assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && rd_en && wr_addr == rd_addr));

endmodule

`default_nettype wire

// ==== logic/npu_controller.sv ====
// ================================================
// Job FSM. Checks LEN, streams buffer reads, tags the
// last word and waits for the activation result.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module npu_controller #(
    parameter int BUF_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  npu_pkg::word_t                 len,
    input  logic                           result_valid,
    output logic                           busy,
    output logic                           done,
    output logic                           error,
    output npu_pkg::ctrl_state_e           state,
    output logic                           rd_en,
    output logic [$clog2(BUF_DEPTH)-1:0]   rd_addr,
    output logic                           clear,
    output logic                           last
);

    localparam int AW = $clog2(BUF_DEPTH);

    logic          len_ok;
    logic [AW-1:0] last_idx;
    logic          rd_last;

    assign len_ok  = len != '0 && len <= npu_pkg::word_t'(BUF_DEPTH);
    assign rd_en   = state == npu_pkg::ST_STREAM;
    assign rd_last = rd_en && rd_addr == last_idx;
    assign busy    = state != npu_pkg::ST_IDLE;
    assign done    = state == npu_pkg::ST_FINISH;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= npu_pkg::ST_IDLE;
            rd_addr  <= '0;
            last_idx <= '0;
            clear    <= 1'b0;
            error    <= 1'b0;
            last     <= 1'b0;
        end else begin
            clear <= 1'b0;
            error <= 1'b0;
            // Tag travels one cycle behind the read, alongside the data
            last  <= rd_last;
            case (state)
                npu_pkg::ST_IDLE: begin
                    if (start && len_ok) begin
                        state    <= npu_pkg::ST_STREAM;
                        rd_addr  <= '0;
                        last_idx <= AW'(len - 32'd1);
                        clear    <= 1'b1;
                    end else if (start) begin
                        error <= 1'b1;
                    end
                end
                npu_pkg::ST_STREAM: begin
                    rd_addr <= rd_addr + AW'(1);
                    if (rd_last) begin
                        state <= npu_pkg::ST_DRAIN;
                    end
                end
                npu_pkg::ST_DRAIN: begin
                    if (result_valid) begin
                        state <= npu_pkg::ST_FINISH;
                    end
                end
                default: state <= npu_pkg::ST_IDLE;
            endcase
        end
    end

    // Reads never run past the last word of the job
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> rd_addr <= last_idx);

endmodule

`default_nettype wire

// ==== logic/mac_lane_array.sv ====
// ================================================
// Four signed 8-bit MAC lanes feeding one 32-bit
// accumulator. Cleared per job, wraps on overflow.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module mac_lane_array (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           clear,
    input  logic           in_valid,
    input  logic           in_last,
    input  npu_pkg::word_t wgt_word,
    input  npu_pkg::word_t act_word,
    output npu_pkg::acc_t  acc,
    output logic           acc_valid
);

    npu_pkg::lane_t wgt_lane [npu_pkg::LANES];
    npu_pkg::lane_t act_lane [npu_pkg::LANES];
    npu_pkg::acc_t  prod     [npu_pkg::LANES];
    npu_pkg::acc_t  prod_sum;

    // Lane 0 sits in the low byte
    for (genvar i = 0; i < npu_pkg::LANES; i++) begin : gen_lane
        assign wgt_lane[i] = wgt_word[i*npu_pkg::LANE_W +: npu_pkg::LANE_W];
        assign act_lane[i] = act_word[i*npu_pkg::LANE_W +: npu_pkg::LANE_W];
        assign prod[i]     = npu_pkg::acc_t'(wgt_lane[i]) * npu_pkg::acc_t'(act_lane[i]);
    end

    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < npu_pkg::LANES; i++) begin
            prod_sum = prod_sum + prod[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            acc_valid <= 1'b0;
        end else begin
            if (clear) begin
                acc <= '0;
            end else if (in_valid) begin
                acc <= acc + prod_sum;
            end
            acc_valid <= in_valid && in_last;
        end
    end

endmodule

`default_nettype wire

// ==== logic/activation_unit.sv ====
// ================================================
// Registered activation stage that passes the sum,
// applies ReLU or applies ReLU clipped at 127
// ================================================
`timescale 1ns/1ps
`default_nettype none

module activation_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  npu_pkg::act_type_e act_type,
    input  npu_pkg::acc_t      acc,
    input  logic               acc_valid,
    output npu_pkg::acc_t      result,
    output logic               result_valid
);

    npu_pkg::acc_t act_out;

    always_comb begin
        case (act_type)
            npu_pkg::ACT_RELU:      act_out = acc[31] ? '0 : acc;
            npu_pkg::ACT_RELU_CLIP: act_out = acc[31] ? '0 : (acc > 32'sd127 ? 32'sd127 : acc);
            default:                act_out = acc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            result <= act_out;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= acc_valid;
        end
    end

endmodule

`default_nettype wire

// ==== logic/npu_regs.sv ====
// ================================================
// Wishbone classic register slave. Holds the register
// file, decodes the two buffer windows into write
// strobes and raises the start pulse and interrupt.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module npu_regs #(
    parameter int BUF_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  npu_pkg::reg_addr_t             wb_adr,
    input  npu_pkg::word_t                 wb_dat_w,
    output logic                           wb_ack,
    output npu_pkg::word_t                 wb_dat_r,
    input  logic                           busy,
    input  logic                           done,
    input  logic                           error,
    input  npu_pkg::ctrl_state_e           state,
    input  npu_pkg::acc_t                  result,
    input  logic                           result_valid,
    output logic                           start,
    output npu_pkg::word_t                 len,
    output npu_pkg::act_type_e             act_type,
    output logic                           wgt_wr_en,
    output logic                           act_wr_en,
    output logic [$clog2(BUF_DEPTH)-1:0]   buf_wr_addr,
    output npu_pkg::word_t                 buf_wr_data,
    output logic                           irq
);

    localparam int AW = $clog2(BUF_DEPTH);

    logic           ack_q;
    logic           req;
    logic           wr;
    logic           in_wgt_win;
    logic           in_act_win;
    logic           idx_ok;
    logic           enable_q;
    logic [1:0]     act_q;
    logic           done_q;
    logic           error_q;
    logic [1:0]     irq_en_q;
    logic [1:0]     irq_sts_q;
    npu_pkg::acc_t  result_q;
    npu_pkg::word_t rd_mux;

    // New transfer seen only when no ack is outstanding
    assign req = wb_cyc && wb_stb && !ack_q;
    assign wr  = req && wb_we;

    assign in_wgt_win = wb_adr[11:8] == npu_pkg::WGT_BASE[11:8];
    assign in_act_win = wb_adr[11:8] == npu_pkg::ACT_BASE[11:8];
    assign idx_ok     = 32'(wb_adr[7:2]) < BUF_DEPTH;

    // ================================================
    // Bus handshake and read path
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_comb begin
        case (wb_adr)
            npu_pkg::REG_CTRL:       rd_mux = {26'b0, act_q, 3'b0, enable_q};
            npu_pkg::REG_STATUS:     rd_mux = {24'b0, state, 3'b0, error_q, done_q, busy};
            npu_pkg::REG_IRQ_EN:     rd_mux = {30'b0, irq_en_q};
            npu_pkg::REG_IRQ_STATUS: rd_mux = {30'b0, irq_sts_q};
            npu_pkg::REG_VERSION:    rd_mux = npu_pkg::NPU_VERSION;
            npu_pkg::REG_CONFIG:     rd_mux = {16'(npu_pkg::LANES), 16'(BUF_DEPTH)};
            npu_pkg::REG_LEN:        rd_mux = len;
            npu_pkg::REG_RESULT:     rd_mux = result_q;
            default:                 rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_mux;
        end
    end

    assign wb_ack = ack_q;

    // ================================================
    // Control registers
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= 1'b0;
            act_q    <= 2'b0;
            irq_en_q <= 2'b0;
            len      <= '0;
            start    <= 1'b0;
        end else begin
            // Start bit is never stored, so it reads back as 0
            start <= wr && wb_adr == npu_pkg::REG_CTRL && wb_dat_w[1] && wb_dat_w[0] && !busy;
            if (wr) begin
                case (wb_adr)
                    npu_pkg::REG_CTRL: begin
                        enable_q <= wb_dat_w[0];
                        act_q    <= wb_dat_w[5:4];
                    end
                    npu_pkg::REG_IRQ_EN: irq_en_q <= wb_dat_w[1:0];
                    npu_pkg::REG_LEN:    len      <= wb_dat_w;
                    default: ;
                endcase
            end
        end
    end

    assign act_type = npu_pkg::act_type_e'(act_q);

    // Sticky status, cleared by the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q    <= 1'b0;
            error_q   <= 1'b0;
            irq_sts_q <= 2'b0;
        end else begin
            if (start) begin
                done_q  <= 1'b0;
                error_q <= 1'b0;
            end
            if (done) begin
                done_q <= 1'b1;
            end
            if (error) begin
                error_q <= 1'b1;
            end
            // New events win over a write-1-to-clear in the same cycle
            if (wr && wb_adr == npu_pkg::REG_IRQ_STATUS) begin
                irq_sts_q <= (irq_sts_q & ~wb_dat_w[1:0]) | {error, done};
            end else begin
                irq_sts_q <= irq_sts_q | {error, done};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid) begin
            result_q <= result;
        end
    end

    assign irq = |(irq_sts_q & irq_en_q);

    // ================================================
    // Buffer window writes
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wgt_wr_en <= 1'b0;
            act_wr_en <= 1'b0;
        end else begin
            wgt_wr_en <= wr && in_wgt_win && idx_ok && !busy;
            act_wr_en <= wr && in_act_win && idx_ok && !busy;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            buf_wr_addr <= wb_adr[AW+1:2];
            buf_wr_data <= wb_dat_w;
        end
    end

    // Host sees ack for one cycle only, never back to back
    assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

// ==== logic/npu_top.sv ====
// ================================================
// NPU slice top level. Wishbone in, irq out; sets the
// buffer depth for every block below it.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module npu_top #(
    parameter int BUF_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  npu_pkg::reg_addr_t wb_adr,
    input  npu_pkg::word_t     wb_dat_w,
    output logic               wb_ack,
    output npu_pkg::word_t     wb_dat_r,
    output logic               irq
);

    localparam int AW = $clog2(BUF_DEPTH);

    // Register block side
    logic                 start;
    npu_pkg::word_t       len;
    npu_pkg::act_type_e   act_type;
    logic                 wgt_wr_en;
    logic                 act_wr_en;
    logic [AW-1:0]        buf_wr_addr;
    npu_pkg::word_t       buf_wr_data;

    // Controller side
    logic                 busy;
    logic                 done;
    logic                 error;
    npu_pkg::ctrl_state_e state;
    logic                 rd_en;
    logic [AW-1:0]        rd_addr;
    logic                 clear;
    logic                 last;

    // Datapath
    npu_pkg::word_t       wgt_rd_data;
    npu_pkg::word_t       act_rd_data;
    logic                 wgt_rd_valid;
    logic                 act_rd_valid;
    npu_pkg::acc_t        acc;
    logic                 acc_valid;
    npu_pkg::acc_t        result;
    logic                 result_valid;

    npu_regs #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .wb_dat_r     (wb_dat_r),
        .busy         (busy),
        .done         (done),
        .error        (error),
        .state        (state),
        .result       (result),
        .result_valid (result_valid),
        .start        (start),
        .len          (len),
        .act_type     (act_type),
        .wgt_wr_en    (wgt_wr_en),
        .act_wr_en    (act_wr_en),
        .buf_wr_addr  (buf_wr_addr),
        .buf_wr_data  (buf_wr_data),
        .irq          (irq)
    );

    npu_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_wgt_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wgt_wr_en),
        .wr_addr  (buf_wr_addr),
        .wr_data  (buf_wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (wgt_rd_data),
        .rd_valid (wgt_rd_valid)
    );

    npu_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_act_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (act_wr_en),
        .wr_addr  (buf_wr_addr),
        .wr_data  (buf_wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (act_rd_data),
        .rd_valid (act_rd_valid)
    );

    npu_controller #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_controller (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .len          (len),
        .result_valid (result_valid),
        .busy         (busy),
        .done         (done),
        .error        (error),
        .state        (state),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .clear        (clear),
        .last         (last)
    );

    mac_lane_array u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .in_valid  (wgt_rd_valid && act_rd_valid),
        .in_last   (last),
        .wgt_word  (wgt_rd_data),
        .act_word  (act_rd_data),
        .acc       (acc),
        .acc_valid (acc_valid)
    );

    activation_unit u_activation (
        .clk          (clk),
        .rst_n        (rst_n),
        .act_type     (act_type),
        .acc          (acc),
        .acc_valid    (acc_valid),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// ==== verif/npu_tb.sv ====
// ================================================
// Testbench for the NPU slice. Loads random buffers
// over Wishbone, runs jobs and checks RESULT, status
// and interrupts against a reference model.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module npu_tb;

    localparam int BUF_DEPTH   = 16;
    localparam int ACK_TIMEOUT = 20;
    localparam int POLL_LIMIT  = 200;

    logic               clk;
    logic               rst_n;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    npu_pkg::reg_addr_t wb_adr;
    npu_pkg::word_t     wb_dat_w;
    logic               wb_ack;
    npu_pkg::word_t     wb_dat_r;
    logic               irq;

    // Model copy of both buffers
    npu_pkg::word_t wgt_mem [BUF_DEPTH];
    npu_pkg::word_t act_mem [BUF_DEPTH];
    npu_pkg::word_t rdata;
    npu_pkg::word_t last_result;
    int             seed = 32817;
    int             job_len;
    int             job_act;

    npu_top #(
        .BUF_DEPTH (BUF_DEPTH)
    ) npu_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ================================================
    // Reporting and bus tasks
    // ================================================
    task automatic check_equal(input string what, input npu_pkg::word_t got,
                               input npu_pkg::word_t expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic wb_transfer(input logic we, input npu_pkg::reg_addr_t addr,
                               input npu_pkg::word_t data);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = data;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                report_timeout("no Wishbone ack for a bus transfer");
            end
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input npu_pkg::reg_addr_t addr, input npu_pkg::word_t data);
        wb_transfer(1'b1, addr, data);
    endtask

    task automatic wb_read(input npu_pkg::reg_addr_t addr, output npu_pkg::word_t data);
        wb_transfer(1'b0, addr, '0);
        data = rdata;
    endtask

    // Poll STATUS until the given flag is set
    task automatic wait_status_bit(input int bit_idx);
        npu_pkg::word_t status;
        int             polls;
        polls = 0;
        do begin
            wb_read(npu_pkg::REG_STATUS, status);
            polls++;
            if (polls > POLL_LIMIT) begin
                report_timeout("STATUS flag never came up after start");
            end
        end while (!status[bit_idx]);
    endtask

    // ================================================
    // Reference model
    // ================================================
    function automatic npu_pkg::word_t expected_result(input int len, input int act);
        int             sum;
        npu_pkg::lane_t w;
        npu_pkg::lane_t a;
        sum = 0;
        for (int i = 0; i < len; i++) begin
            for (int l = 0; l < 4; l++) begin
                w   = wgt_mem[i][8*l +: 8];
                a   = act_mem[i][8*l +: 8];
                sum = sum + int'(w) * int'(a);
            end
        end
        if (act == 1 || act == 2) begin
            if (sum < 0) begin
                sum = 0;
            end
        end
        if (act == 2 && sum > 127) begin
            sum = 127;
        end
        return npu_pkg::word_t'(sum);
    endfunction

    task automatic fill_buffers();
        for (int i = 0; i < BUF_DEPTH; i++) begin
            wgt_mem[i] = $random(seed);
            act_mem[i] = $random(seed);
            wb_write(npu_pkg::reg_addr_t'(npu_pkg::WGT_BASE + 12'(i*4)), wgt_mem[i]);
            wb_write(npu_pkg::reg_addr_t'(npu_pkg::ACT_BASE + 12'(i*4)), act_mem[i]);
        end
    endtask

    // LEN first, then enable and start with the activation type
    task automatic start_job(input int len, input int act);
        wb_write(npu_pkg::REG_LEN, npu_pkg::word_t'(len));
        wb_write(npu_pkg::REG_CTRL, npu_pkg::word_t'(32'h3 | (act << 4)));
    endtask

    task automatic run_job(input int len, input int act);
        fill_buffers();
        start_job(len, act);
        wait_status_bit(1);
        wb_read(npu_pkg::REG_RESULT, rdata);
        check_equal("RESULT", rdata, expected_result(len, act));
        last_result = rdata;
        wb_read(npu_pkg::REG_CTRL, rdata);
        check_equal("CTRL start bit", npu_pkg::word_t'(rdata[1]), '0);
    endtask

    task automatic run_bad_len(input int len);
        start_job(len, 0);
        wait_status_bit(2);
        wb_read(npu_pkg::REG_IRQ_STATUS, rdata);
        check_equal("IRQ_STATUS error", npu_pkg::word_t'(rdata[1]), 32'd1);
        wb_read(npu_pkg::REG_RESULT, rdata);
        check_equal("RESULT after bad LEN", rdata, last_result);
        wb_write(npu_pkg::REG_IRQ_STATUS, 32'h3);
    endtask

    // ================================================
    // Main sequence
    // ================================================
    initial begin
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_equal("irq after reset", npu_pkg::word_t'(irq), '0);
        wb_read(npu_pkg::REG_VERSION, rdata);
        check_equal("VERSION", rdata, 32'h0001_0000);
        wb_read(npu_pkg::REG_CONFIG, rdata);
        check_equal("CONFIG", rdata, {16'd4, 16'(BUF_DEPTH)});
        wb_read(npu_pkg::REG_CTRL, rdata);
        check_equal("CTRL after reset", rdata, '0);
        wb_read(npu_pkg::REG_STATUS, rdata);
        check_equal("STATUS after reset", rdata, '0);
        wb_read(npu_pkg::REG_IRQ_STATUS, rdata);
        check_equal("IRQ_STATUS after reset", rdata, '0);
        wb_read(12'h040, rdata);
        check_equal("unmapped read", rdata, '0);

        for (int j = 0; j < 20; j++) begin
            job_len = ($random(seed) & 15) + 1;
            job_act = $random(seed) & 3;
            run_job(job_len, job_act);
        end

        // Done interrupt, then write-1-to-clear
        wb_write(npu_pkg::REG_IRQ_STATUS, 32'h3);
        wb_write(npu_pkg::REG_IRQ_EN, 32'h1);
        run_job(($random(seed) & 15) + 1, $random(seed) & 3);
        check_equal("irq after done", npu_pkg::word_t'(irq), 32'd1);
        wb_read(npu_pkg::REG_IRQ_STATUS, rdata);
        check_equal("IRQ_STATUS done", npu_pkg::word_t'(rdata[0]), 32'd1);
        wb_write(npu_pkg::REG_IRQ_STATUS, 32'h1);
        check_equal("irq after clear", npu_pkg::word_t'(irq), '0);
        wb_read(npu_pkg::REG_IRQ_STATUS, rdata);
        check_equal("IRQ_STATUS done cleared", npu_pkg::word_t'(rdata[0]), '0);

        run_bad_len(0);
        run_bad_len(BUF_DEPTH + 1);

        // Start with enable low is ignored for a valid LEN
        wb_write(npu_pkg::REG_LEN, 32'd4);
        wb_write(npu_pkg::REG_CTRL, 32'h2);
        for (int p = 0; p < 20; p++) begin
            wb_read(npu_pkg::REG_STATUS, rdata);
            check_equal("STATUS busy and done", npu_pkg::word_t'(rdata[1:0]), '0);
        end
        wb_read(npu_pkg::REG_RESULT, rdata);
        check_equal("RESULT after disabled start", rdata, last_result);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/npu_pkg.sv
logic/npu_buffer.sv
logic/npu_controller.sv
logic/mac_lane_array.sv
logic/activation_unit.sv
logic/npu_regs.sv
logic/npu_top.sv
verif/npu_tb.sv

// ==== Makefile ====
SIM_LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module npu_tb -f filelist.f -o npu_sim

run: build
	./obj_dir/npu_sim 2>&1 | tee $(SIM_LOG)
	@if grep -q "Regression failed" $(SIM_LOG); then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -q "Regression passed" $(SIM_LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	verilator --lint-only --timing --assert --top-module npu_tb -f filelist.f

clean:
	rm -rf obj_dir $(SIM_LOG)
